// ==== rtl/rob_pkg.sv ====
package rob_pkg;

	// number of reorder-buffer slots, a power of two keeps the tag compact
	localparam int ROB_SIZE = 8;

	// tag width follows the slot count
	localparam int ROB_TAG_W = $clog2(ROB_SIZE);

	// index of one reorder-buffer slot
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;

	// occupancy needs one extra bit to reach ROB_SIZE itself
	typedef logic [ROB_TAG_W:0] rob_count_t;

	// next slot in program order, wraps after the last entry
	function automatic rob_tag_t rob_tag_next(input rob_tag_t tag);
		if (tag == rob_tag_t'(ROB_SIZE - 1)) begin
			return '0;
		end
		return tag + rob_tag_t'(1);
	endfunction

	// occupancy constants used by the pointer logic
	localparam rob_count_t ROB_EMPTY = '0;
	localparam rob_count_t ROB_FULL  = rob_count_t'(ROB_SIZE);

endpackage

// ==== rtl/cdb_pkg.sv ====
package cdb_pkg;

	// width of one data word on the bus
	localparam int WORD_SIZE = 32;

	// alu result ports feeding the bus
	localparam int ALU_NUM = 3;

	// all bus sources, the store unit sits after the alus
	localparam int SRC_NUM = ALU_NUM + 1;

	typedef logic [WORD_SIZE-1:0] word_t;

	// an alu hands over a single word
	typedef word_t alu_result_t;

	// the store unit hands over address and data together
	typedef struct packed {
		word_t addr;
		word_t data;
	} store_result_t;

	// index of one bus source
	typedef logic [$clog2(SRC_NUM)-1:0] src_sel_t;

	// the store unit is the last source and the only one with an address
	localparam src_sel_t STORE_SRC = src_sel_t'(SRC_NUM - 1);

endpackage

// ==== rtl/result_skid.sv ====
`timescale 1ns/1ps

module result_skid #(
	parameter type payload_t = cdb_pkg::alu_result_t
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	output logic              in_ready,
	input  rob_pkg::rob_tag_t in_tag,
	input  payload_t          in_payload,
	output logic              out_valid,
	input  logic              out_ready,
	output rob_pkg::rob_tag_t out_tag,
	output payload_t          out_payload
);
	import rob_pkg::*;

	// two slots used as a small circular queue, oldest at rd_ptr
	rob_tag_t   tag_q [2];
	payload_t   payload_q [2];
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count_q;
	logic       push;
	logic       pop;

	// only a completely full buffer stalls the unit
	assign in_ready  = (count_q != 2'd2);
	assign out_valid = (count_q != 2'd0);

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	assign out_tag     = tag_q[rd_ptr];
	assign out_payload = payload_q[rd_ptr];

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr  <= 1'b0;
			rd_ptr  <= 1'b0;
			count_q <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 2'd1;
				2'b01: count_q <= count_q - 2'd1;
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			tag_q[wr_ptr]     <= in_tag;
			payload_q[wr_ptr] <= in_payload;
		end
	end

endmodule

// ==== rtl/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
	input  logic              clk,
	input  logic              reset,
	input  logic              src_valid [cdb_pkg::SRC_NUM],
	output logic              src_ready [cdb_pkg::SRC_NUM],
	input  rob_pkg::rob_tag_t src_tag [cdb_pkg::SRC_NUM],
	input  cdb_pkg::word_t    src_data [cdb_pkg::SRC_NUM],
	input  cdb_pkg::word_t    store_addr,
	output logic              cdb_valid,
	output rob_pkg::rob_tag_t cdb_tag,
	output cdb_pkg::word_t    cdb_data,
	output cdb_pkg::word_t    cdb_addr
);
	import cdb_pkg::*;

	// source that won the last grant
	src_sel_t last_sel;
	src_sel_t grant_sel;
	logic     grant_any;

	// scan from the farthest source down to the one right after the last winner,
	// so the nearest valid source overwrites the others and wins
	always_comb begin
		src_sel_t cand;
		cand      = last_sel;
		grant_any = 1'b0;
		grant_sel = last_sel;
		for (int k = SRC_NUM; k >= 1; k--) begin
			cand = src_sel_t'((int'(last_sel) + k) % SRC_NUM);
			if (src_valid[cand]) begin
				grant_any = 1'b1;
				grant_sel = cand;
			end
		end
	end

	// the bus never stalls, so a grant is the ready for that source
	always_comb begin
		for (int i = 0; i < SRC_NUM; i++) begin
			src_ready[i] = grant_any && (grant_sel == src_sel_t'(i));
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cdb_valid <= 1'b0;
			// start so that source 0 has first priority
			last_sel  <= STORE_SRC;
		end else begin
			cdb_valid <= grant_any;
			if (grant_any) begin
				last_sel <= grant_sel;
			end
		end
	end

	// broadcast payload, only meaningful while cdb_valid is high
	always_ff @(posedge clk) begin
		if (grant_any) begin
			cdb_tag  <= src_tag[grant_sel];
			cdb_data <= src_data[grant_sel];
			if (grant_sel == STORE_SRC) begin
				cdb_addr <= store_addr;
			end else begin
				cdb_addr <= '0;
			end
		end
	end

endmodule

// ==== rtl/rob_entry_file.sv ====
`timescale 1ns/1ps

module rob_entry_file (
	input  logic              clk,
	input  logic              reset,
	input  logic              alloc_en,
	input  rob_pkg::rob_tag_t alloc_tag,
	input  logic              alloc_is_store,
	input  logic              cdb_valid,
	input  rob_pkg::rob_tag_t cdb_tag,
	input  cdb_pkg::word_t    cdb_data,
	input  cdb_pkg::word_t    cdb_addr,
	input  rob_pkg::rob_tag_t head_tag,
	output logic              head_done,
	output logic              head_is_store,
	output cdb_pkg::word_t    head_data,
	output cdb_pkg::word_t    head_addr
);
	import rob_pkg::*;
	import cdb_pkg::*;

	// flat per-entry storage, one element per slot
	logic [ROB_SIZE-1:0]  done_q;
	logic [ROB_SIZE-1:0]  is_store_q;
	word_t [ROB_SIZE-1:0] data_q;
	word_t [ROB_SIZE-1:0] addr_q;

	// done flags
	always_ff @(posedge clk) begin
		if (reset) begin
			done_q <= '0;
		end else begin
			if (alloc_en) begin
				done_q[alloc_tag] <= 1'b0;
			end
			// a slot on the bus is never the one being allocated
			if (cdb_valid) begin
				done_q[cdb_tag] <= 1'b1;
			end
		end
	end

	// store flag is captured at dispatch
	always_ff @(posedge clk) begin
		if (alloc_en) begin
			is_store_q[alloc_tag] <= alloc_is_store;
		end
	end

	// bus beat merges into its slot, other slots keep their values
	always_ff @(posedge clk) begin
		if (cdb_valid) begin
			data_q[cdb_tag] <= cdb_data;
			addr_q[cdb_tag] <= cdb_addr;
		end
	end

	// head entry is read straight out for commit
	assign head_done     = done_q[head_tag];
	assign head_is_store = is_store_q[head_tag];
	assign head_data     = data_q[head_tag];
	assign head_addr     = addr_q[head_tag];

endmodule

// ==== rtl/rob_control.sv ====
`timescale 1ns/1ps

module rob_control (
	input  logic              clk,
	input  logic              reset,
	input  logic              disp_valid,
	output logic              disp_ready,
	output rob_pkg::rob_tag_t disp_tag,
	output logic              alloc_en,
	input  logic              head_done,
	output rob_pkg::rob_tag_t head_tag,
	output logic              commit_valid,
	input  logic              commit_ready
);
	import rob_pkg::*;

	rob_tag_t   head_q;
	rob_tag_t   tail_q;
	rob_count_t count_q;
	logic       commit_en;

	// dispatch side, the tail slot is always offered
	assign disp_ready = (count_q < ROB_FULL);
	assign disp_tag   = tail_q;
	assign alloc_en   = disp_valid && disp_ready;

	// commit side, oldest entry leaves only once its result is in
	assign head_tag     = head_q;
	assign commit_valid = (count_q != ROB_EMPTY) && head_done;
	assign commit_en    = commit_valid && commit_ready;

	// pointers
	always_ff @(posedge clk) begin
		if (reset) begin
			head_q <= '0;
			tail_q <= '0;
		end else begin
			if (alloc_en) begin
				tail_q <= rob_tag_next(tail_q);
			end
			if (commit_en) begin
				head_q <= rob_tag_next(head_q);
			end
		end
	end

	// occupancy, allocate and commit in one cycle cancel out
	always_ff @(posedge clk) begin
		if (reset) begin
			count_q <= ROB_EMPTY;
		end else begin
			case ({alloc_en, commit_en})
				2'b10: count_q <= count_q + rob_count_t'(1);
				2'b01: count_q <= count_q - rob_count_t'(1);
				default: count_q <= count_q;
			endcase
		end
	end

endmodule

// ==== rtl/rob_writeback.sv ====
`timescale 1ns/1ps

module rob_writeback (
	input  logic                 clk,
	input  logic                 reset,
	// dispatch
	input  logic                 disp_valid,
	output logic                 disp_ready,
	input  logic                 disp_is_store,
	output rob_pkg::rob_tag_t    disp_tag,
	// alu result ports
	input  logic                 alu_valid [cdb_pkg::ALU_NUM],
	output logic                 alu_ready [cdb_pkg::ALU_NUM],
	input  rob_pkg::rob_tag_t    alu_tag [cdb_pkg::ALU_NUM],
	input  cdb_pkg::alu_result_t alu_data [cdb_pkg::ALU_NUM],
	// store address unit
	input  logic                 st_valid,
	output logic                 st_ready,
	input  rob_pkg::rob_tag_t    st_tag,
	input  cdb_pkg::word_t       st_addr,
	input  cdb_pkg::word_t       st_data,
	// common data bus, also exported for forwarding
	output logic                 cdb_valid,
	output rob_pkg::rob_tag_t    cdb_tag,
	output cdb_pkg::word_t       cdb_data,
	output cdb_pkg::word_t       cdb_addr,
	// commit
	output logic                 commit_valid,
	input  logic                 commit_ready,
	output rob_pkg::rob_tag_t    commit_tag,
	output cdb_pkg::word_t       commit_data,
	output cdb_pkg::word_t       commit_addr,
	output logic                 commit_is_store
);
	import rob_pkg::*;
	import cdb_pkg::*;

	// arbiter side of the skid buffers, index STORE_SRC is the store unit
	logic          src_valid [SRC_NUM];
	logic          src_ready [SRC_NUM];
	rob_tag_t      src_tag [SRC_NUM];
	word_t         src_data [SRC_NUM];
	store_result_t st_in_payload;
	store_result_t st_out_payload;
	logic          alloc_en;
	logic          head_done;

	for (genvar i = 0; i < ALU_NUM; i++) begin : g_alu_skid
		result_skid #(
			.payload_t(alu_result_t)
		) i_alu_skid (
			.clk        (clk),
			.reset      (reset),
			.in_valid   (alu_valid[i]),
			.in_ready   (alu_ready[i]),
			.in_tag     (alu_tag[i]),
			.in_payload (alu_data[i]),
			.out_valid  (src_valid[i]),
			.out_ready  (src_ready[i]),
			.out_tag    (src_tag[i]),
			.out_payload(src_data[i])
		);
	end

	// address and data travel together through the store buffer
	assign st_in_payload       = '{addr: st_addr, data: st_data};
	assign src_data[STORE_SRC] = st_out_payload.data;

	result_skid #(
		.payload_t(store_result_t)
	) i_store_skid (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (st_valid),
		.in_ready   (st_ready),
		.in_tag     (st_tag),
		.in_payload (st_in_payload),
		.out_valid  (src_valid[STORE_SRC]),
		.out_ready  (src_ready[STORE_SRC]),
		.out_tag    (src_tag[STORE_SRC]),
		.out_payload(st_out_payload)
	);

	cdb_arbiter i_cdb_arbiter (
		.clk       (clk),
		.reset     (reset),
		.src_valid (src_valid),
		.src_ready (src_ready),
		.src_tag   (src_tag),
		.src_data  (src_data),
		.store_addr(st_out_payload.addr),
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.cdb_data  (cdb_data),
		.cdb_addr  (cdb_addr)
	);

	rob_entry_file i_rob_entry_file (
		.clk           (clk),
		.reset         (reset),
		.alloc_en      (alloc_en),
		.alloc_tag     (disp_tag),
		.alloc_is_store(disp_is_store),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.cdb_data      (cdb_data),
		.cdb_addr      (cdb_addr),
		.head_tag      (commit_tag),
		.head_done     (head_done),
		.head_is_store (commit_is_store),
		.head_data     (commit_data),
		.head_addr     (commit_addr)
	);

	rob_control i_rob_control (
		.clk         (clk),
		.reset       (reset),
		.disp_valid  (disp_valid),
		.disp_ready  (disp_ready),
		.disp_tag    (disp_tag),
		.alloc_en    (alloc_en),
		.head_done   (head_done),
		.head_tag    (commit_tag),
		.commit_valid(commit_valid),
		.commit_ready(commit_ready)
	);

endmodule

// ==== verif/rob_writeback_tb.sv ====
`timescale 1ns/1ps

module rob_writeback_tb;
	import rob_pkg::*;
	import cdb_pkg::*;

	// life of one slot as the model sees it
	typedef enum int {S_FREE, S_WAIT, S_HELD, S_SENT, S_DONE} slot_state_t;

	logic clk;
	logic reset;
	logic disp_valid;
	logic disp_ready;
	logic disp_is_store;
	rob_tag_t disp_tag;
	logic alu_valid [ALU_NUM];
	logic alu_ready [ALU_NUM];
	rob_tag_t alu_tag [ALU_NUM];
	alu_result_t alu_data [ALU_NUM];
	logic st_valid;
	logic st_ready;
	rob_tag_t st_tag;
	word_t st_addr;
	word_t st_data;
	logic cdb_valid;
	rob_tag_t cdb_tag;
	word_t cdb_data;
	word_t cdb_addr;
	logic commit_valid;
	logic commit_ready;
	rob_tag_t commit_tag;
	word_t commit_data;
	word_t commit_addr;
	logic commit_is_store;

	// reorder-buffer model indexed by tag
	slot_state_t slot_state [ROB_SIZE];
	word_t exp_data [ROB_SIZE];
	word_t exp_addr [ROB_SIZE];
	logic exp_store [ROB_SIZE];
	int sent_cycle [ROB_SIZE];
	rob_tag_t disp_q [$];
	rob_tag_t tail_model;
	logic port_hold [SRC_NUM];
	rob_tag_t port_tag [SRC_NUM];
	logic prev_stall;
	rob_tag_t prev_tag;
	word_t prev_data;
	word_t prev_addr;
	logic prev_store;
	logic seen_disp_ready;
	logic [31:0] lfsr_state;
	int disp_left, disp_pct, store_pct, send_pct, commit_pct;
	int cycle_count, err_count, errs_at_start, check_count, test_count, fail_count;
	string test_name;

	rob_writeback i_rob_writeback (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic percent(input int pct);
		return (rand_bits(7) % 100) < pct;
	endfunction

	task automatic check_word(input string what, input word_t exp, input word_t act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_tag(input string what, input rob_tag_t exp, input rob_tag_t act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("Fail %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic report_problem(input string msg);
		err_count++;
		$display("Error in %s: %s", test_name, msg);
	endtask

	// sample at the falling edge and drive for the next rising edge
	task automatic step();
		rob_tag_t cand [$];
		rob_tag_t t;
		logic go;
		@(negedge clk);
		cycle_count++;
		seen_disp_ready = disp_ready;
		check_flag("disp_ready", disp_q.size() < ROB_SIZE, disp_ready);
		check_tag("disp_tag", tail_model, disp_tag);
		check_flag("commit_valid", disp_q.size() != 0 && slot_state[disp_q[0]] == S_DONE,
			commit_valid);
		if (prev_stall) begin
			check_tag("stalled commit_tag", prev_tag, commit_tag);
			check_word("stalled commit_data", prev_data, commit_data);
			check_word("stalled commit_addr", prev_addr, commit_addr);
			check_flag("stalled commit_is_store", prev_store, commit_is_store);
		end
		commit_ready = percent(commit_pct);
		prev_stall = commit_valid && !commit_ready;
		prev_tag = commit_tag;
		prev_data = commit_data;
		prev_addr = commit_addr;
		prev_store = commit_is_store;
		if (commit_valid && commit_ready && disp_q.size() != 0) begin
			t = disp_q.pop_front();
			check_tag("commit_tag", t, commit_tag);
			check_word("commit_data", exp_data[t], commit_data);
			check_word("commit_addr", exp_addr[t], commit_addr);
			check_flag("commit_is_store", exp_store[t], commit_is_store);
			slot_state[t] = S_FREE;
		end
		// each sent result shows up on the bus once and no sooner than two cycles after its transfer
		if (cdb_valid) begin
			if (slot_state[cdb_tag] != S_SENT) begin
				report_problem($sformatf("bus beat for tag %0d that was not waiting", cdb_tag));
			end else begin
				check_word("cdb_data", exp_data[cdb_tag], cdb_data);
				check_word("cdb_addr", exp_addr[cdb_tag], cdb_addr);
				if (cycle_count - sent_cycle[cdb_tag] < 2) begin
					report_problem($sformatf("tag %0d reached the bus too early", cdb_tag));
				end
				slot_state[cdb_tag] = S_DONE;
			end
		end
		for (int i = 0; i < SRC_NUM; i++) begin
			if (!port_hold[i] && percent(send_pct)) begin
				cand.delete();
				foreach (disp_q[j]) begin
					if (slot_state[disp_q[j]] == S_WAIT &&
						exp_store[disp_q[j]] == (i == SRC_NUM - 1)) begin
						cand.push_back(disp_q[j]);
					end
				end
				if (cand.size() != 0) begin
					port_tag[i] = cand[rand_bits(3) % cand.size()];
					port_hold[i] = 1'b1;
					slot_state[port_tag[i]] = S_HELD;
				end
			end
			t = port_tag[i];
			if (i < ALU_NUM) begin
				alu_valid[i] = port_hold[i];
				alu_tag[i] = t;
				alu_data[i] = exp_data[t];
				go = alu_ready[i];
			end else begin
				st_valid = port_hold[i];
				st_tag = t;
				st_addr = exp_addr[t];
				st_data = exp_data[t];
				go = st_ready;
			end
			if (port_hold[i] && go) begin
				slot_state[t] = S_SENT;
				sent_cycle[t] = cycle_count;
				port_hold[i] = 1'b0;
			end
		end
		// new slots become eligible for results from the next cycle on
		go = disp_left > 0 && percent(disp_pct);
		disp_valid = go;
		disp_is_store = percent(store_pct);
		if (go && disp_ready) begin
			t = tail_model;
			exp_store[t] = disp_is_store;
			exp_data[t] = rand_bits(32);
			exp_addr[t] = disp_is_store ? rand_bits(32) : '0;
			slot_state[t] = S_WAIT;
			disp_q.push_back(t);
			tail_model = rob_tag_t'((int'(tail_model) + 1) % ROB_SIZE);
			disp_left--;
		end
	endtask

	task automatic start_test(input string name, input int n, input int d, input int s,
		input int snd, input int c);
		test_name = name;
		errs_at_start = err_count;
		disp_left = n;
		disp_pct = d;
		store_pct = s;
		send_pct = snd;
		commit_pct = c;
	endtask

	// dispatch until every slot is taken
	task automatic fill_rob(input int limit);
		int guard;
		guard = 0;
		while (disp_q.size() < ROB_SIZE && guard < limit) begin
			step();
			guard++;
		end
		if (guard >= limit) begin
			report_problem("timeout while filling the reorder buffer");
		end
	endtask

	task automatic drain(input int limit);
		int guard;
		guard = 0;
		while ((disp_left > 0 || disp_q.size() != 0) && guard < limit) begin
			step();
			guard++;
		end
		if (guard >= limit) begin
			report_problem($sformatf("timeout with %0d entries not committed", disp_q.size()));
		end
	endtask

	task automatic end_test();
		test_count++;
		if (err_count != errs_at_start) begin
			fail_count++;
			$display("test %s: %0d errors", test_name, err_count - errs_at_start);
		end else begin
			$display("test %s: ok", test_name);
		end
	endtask

	initial begin
		lfsr_state = 32'hcc88ef9c;
		reset = 1'b1;
		disp_valid = 1'b0;
		disp_is_store = 1'b0;
		commit_ready = 1'b0;
		st_valid = 1'b0;
		st_tag = '0;
		st_addr = '0;
		st_data = '0;
		for (int i = 0; i < ALU_NUM; i++) begin
			alu_valid[i] = 1'b0;
			alu_tag[i] = '0;
			alu_data[i] = '0;
		end
		for (int i = 0; i < SRC_NUM; i++) begin
			port_hold[i] = 1'b0;
			port_tag[i] = '0;
		end
		for (int t = 0; t < ROB_SIZE; t++) begin
			slot_state[t] = S_FREE;
			exp_data[t] = '0;
			exp_addr[t] = '0;
			exp_store[t] = 1'b0;
			sent_cycle[t] = 0;
		end
		tail_model = '0;
		prev_stall = 1'b0;
		{cycle_count, err_count, check_count, test_count, fail_count} = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		start_test("reset", 0, 0, 0, 0, 0);
		check_flag("commit_valid", 1'b0, commit_valid);
		check_flag("cdb_valid", 1'b0, cdb_valid);
		check_flag("disp_ready", 1'b1, disp_ready);
		check_flag("st_ready", 1'b1, st_ready);
		for (int i = 0; i < ALU_NUM; i++) begin
			check_flag("alu_ready", 1'b1, alu_ready[i]);
		end
		reset = 1'b0;
		end_test();

		start_test("alu_out_of_order", 40, 70, 0, 40, 100);
		drain(2000);
		end_test();
		start_test("store_commit", 40, 70, 50, 40, 100);
		drain(2000);
		end_test();

		// fill every slot with commit held off and then let the tail wrap around
		start_test("full_wrap", ROB_SIZE + 5, 100, 30, 100, 0);
		fill_rob(200);
		step();
		check_flag("disp_ready when full", 1'b0, seen_disp_ready);
		commit_pct = 100;
		drain(2000);
		end_test();

		start_test("random_commit_ready", 60, 80, 30, 60, 50);
		drain(4000);
		end_test();

		// results wait until every slot is taken so that all ports load at once
		start_test("all_sources_busy", 80, 100, 40, 0, 0);
		fill_rob(200);
		send_pct = 100;
		commit_pct = 100;
		drain(4000);
		end_test();

		$display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
			test_count, fail_count, check_count, err_count);
		if (err_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== rob_writeback.f ====
rtl/rob_pkg.sv
rtl/cdb_pkg.sv
rtl/result_skid.sv
rtl/cdb_arbiter.sv
rtl/rob_entry_file.sv
rtl/rob_control.sv
rtl/rob_writeback.sv
verif/rob_writeback_tb.sv

// ==== Makefile ====
# Verilator build and run for the reorder-buffer write-back testbench

VERILATOR ?= verilator
TOP       ?= rob_writeback_tb
FILELIST  ?= rob_writeback.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell cat $(FILELIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(EXE): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(EXE)
	./$(EXE) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
